//--- rtl/axil_packer_pkg.sv
/*
 * AXI4-Lite store packer package
 * Widths, AXI response and protection codes, channel payloads and the
 * packed command word shared by the design and its testbench
 */
`default_nettype none

package axil_packer_pkg;

  localparam int AXIL_ADDR_WIDTH    = 32;
  localparam int AXIL_DATA_WIDTH    = 32;
  localparam int PAYLOAD_DATA_WIDTH = 8;
  // Whatever is left of the command word after the op bit and the data
  localparam int PAYLOAD_ADDR_WIDTH = AXIL_DATA_WIDTH - PAYLOAD_DATA_WIDTH - 1;
  localparam int MEM_ADDR_WIDTH     = 10;

  typedef enum logic [1:0] {
    e_axi_resp_okay   = 2'b00,
    e_axi_resp_exokay = 2'b01,
    e_axi_resp_slverr = 2'b10,
    e_axi_resp_decerr = 2'b11
  } axi_resp_e;

  typedef enum logic [2:0] {
    e_axi_prot_default   = 3'b000,
    e_axi_prot_priv      = 3'b001,
    e_axi_prot_nonsecure = 3'b010,
    e_axi_prot_instr     = 3'b100
  } axi_prot_e;

  // Op bit on top, byte data at the bottom
  typedef struct packed {
    logic                          write_not_read;
    logic [PAYLOAD_ADDR_WIDTH-1:0] addr;
    logic [PAYLOAD_DATA_WIDTH-1:0] data;
  } packed_cmd_s;

  typedef struct packed {
    logic [AXIL_ADDR_WIDTH-1:0] addr;
    axi_prot_e                  prot;
  } axil_aw_s;

  typedef struct packed {
    logic [AXIL_DATA_WIDTH-1:0]   data;
    logic [AXIL_DATA_WIDTH/8-1:0] strb;
  } axil_w_s;

  typedef struct packed {
    logic [AXIL_ADDR_WIDTH-1:0] addr;
    axi_prot_e                  prot;
  } axil_ar_s;

  typedef struct packed {
    logic [AXIL_DATA_WIDTH-1:0] data;
    axi_resp_e                  resp;
  } axil_r_s;

  typedef struct packed {
    axi_resp_e resp;
  } axil_b_s;

  // Read byte zero-extended to the full data width
  typedef logic [AXIL_DATA_WIDTH-1:0] mem_resp_t;

endpackage

`default_nettype wire

//--- rtl/cmd_fifo.sv
/*
 * Two-entry valid/ready FIFO
 * Circular buffer with registered output, full throughput
 */
`default_nettype none

module cmd_fifo #(
  parameter int WIDTH = 32
) (
  input  wire logic             clk_i,
  input  wire logic             reset_i,

  input  wire logic [WIDTH-1:0] data_i,
  input  wire logic             v_i,
  output logic                  ready_o,

  output logic [WIDTH-1:0]      data_o,
  output logic                  v_o,
  input  wire logic             ready_i
);

  logic [WIDTH-1:0] mem_r [2];
  logic             wr_ptr_r;
  logic             rd_ptr_r;
  logic [1:0]       count_r;
  logic             push;
  logic             pop;

  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rd_ptr_r];

  assign push = v_i & ready_o;
  assign pop  = v_o & ready_i;

  // Storage only
  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wr_ptr_r] <= data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= ~wr_ptr_r;
      if (pop)
        rd_ptr_r <= ~rd_ptr_r;
      count_r <= count_r + {1'b0, push} - {1'b0, pop};
    end
  end

  // Upstream keeps offering an item the full FIFO could not take
  a_no_drop: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i && (count_r == 2'd2) |=> v_i);

endmodule

`default_nettype wire

//--- rtl/byte_mem_target.sv
/*
 * Byte memory target
 * Executes packed commands on a byte array; reads come back
 * zero-extended through a registered response
 */
`default_nettype none

module byte_mem_target (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,

  input  wire axil_packer_pkg::packed_cmd_s  cmd_i,
  input  wire logic                          cmd_v_i,
  output logic                               cmd_ready_o,

  output axil_packer_pkg::mem_resp_t         resp_o,
  output logic                               resp_v_o,
  input  wire logic                          resp_ready_i
);

  localparam int DEPTH = 2 ** axil_packer_pkg::MEM_ADDR_WIDTH;

  logic [axil_packer_pkg::PAYLOAD_DATA_WIDTH-1:0] mem_r [DEPTH];
  logic [axil_packer_pkg::PAYLOAD_DATA_WIDTH-1:0] rdata_r;
  logic [axil_packer_pkg::MEM_ADDR_WIDTH-1:0]     index;
  logic                                           pending_r;
  logic                                           accept;
  logic                                           do_write;
  logic                                           do_read;

  // Upper address bits alias onto the same bytes
  assign index = cmd_i.addr[axil_packer_pkg::MEM_ADDR_WIDTH-1:0];

  // A read needs room downstream, a write does not
  assign cmd_ready_o = ~pending_r & (resp_ready_i | cmd_i.write_not_read);
  assign accept      = cmd_v_i & cmd_ready_o;
  assign do_write    = accept & cmd_i.write_not_read;
  assign do_read     = accept & ~cmd_i.write_not_read;

  assign resp_v_o = pending_r;
  assign resp_o   = {{(axil_packer_pkg::AXIL_DATA_WIDTH -
                       axil_packer_pkg::PAYLOAD_DATA_WIDTH){1'b0}}, rdata_r};

  always_ff @(posedge clk_i)
  begin
    if (do_write)
      mem_r[index] <= cmd_i.data;
    if (do_read)
      rdata_r <= mem_r[index];
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      pending_r <= 1'b0;
    else if (do_read)
      pending_r <= 1'b1;
    else if (resp_v_o & resp_ready_i)
      pending_r <= 1'b0;
  end

  // Single outstanding read, so the response FIFO still has room next cycle
  a_resp_room: assert property (@(posedge clk_i) disable iff (reset_i)
    do_read |=> resp_v_o && resp_ready_i);

endmodule

`default_nettype wire

//--- rtl/axil_store_packer.sv
/*
 * AXI4-Lite store packer
 * Turns each AXI4-Lite write or read into one packed command word and
 * returns the matching B or R response, one transaction at a time
 */
`default_nettype none

module axil_store_packer (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,

  input  wire axil_packer_pkg::axil_aw_s     s_axil_aw_i,
  input  wire logic                          s_axil_awvalid_i,
  output logic                               s_axil_awready_o,

  input  wire axil_packer_pkg::axil_w_s      s_axil_w_i,
  input  wire logic                          s_axil_wvalid_i,
  output logic                               s_axil_wready_o,

  output axil_packer_pkg::axil_b_s           s_axil_b_o,
  output logic                               s_axil_bvalid_o,
  input  wire logic                          s_axil_bready_i,

  input  wire axil_packer_pkg::axil_ar_s     s_axil_ar_i,
  input  wire logic                          s_axil_arvalid_i,
  output logic                               s_axil_arready_o,

  output axil_packer_pkg::axil_r_s           s_axil_r_o,
  output logic                               s_axil_rvalid_o,
  input  wire logic                          s_axil_rready_i,

  output axil_packer_pkg::packed_cmd_s       cmd_o,
  output logic                               cmd_v_o,
  input  wire logic                          cmd_ready_i,

  input  wire axil_packer_pkg::mem_resp_t    resp_i,
  input  wire logic                          resp_v_i,
  output logic                               resp_ready_o
);

  typedef enum logic [1:0] {
    e_idle,
    e_write_resp,
    e_read_resp
  } state_e;

  state_e state_r;
  state_e state_n;

  logic is_idle;
  logic pick_read;
  logic pick_write;
  logic accept;

  assign is_idle    = (state_r == e_idle);
  // Reads win over a write offered in the same cycle
  assign pick_read  = s_axil_arvalid_i;
  assign pick_write = ~s_axil_arvalid_i & s_axil_awvalid_i & s_axil_wvalid_i;

  assign cmd_v_o = is_idle & (pick_read | pick_write);
  assign accept  = cmd_v_o & cmd_ready_i;

  // Address handshakes complete in the cycle the command is accepted
  assign s_axil_arready_o = is_idle & cmd_ready_i & pick_read;
  assign s_axil_awready_o = is_idle & cmd_ready_i & pick_write;
  assign s_axil_wready_o  = is_idle & cmd_ready_i & pick_write;

  always_comb
  begin
    if (pick_read)
    begin
      cmd_o.write_not_read = 1'b0;
      cmd_o.addr           = s_axil_ar_i.addr[axil_packer_pkg::PAYLOAD_ADDR_WIDTH-1:0];
      cmd_o.data           = '0;
    end
    else
    begin
      cmd_o.write_not_read = 1'b1;
      cmd_o.addr           = s_axil_aw_i.addr[axil_packer_pkg::PAYLOAD_ADDR_WIDTH-1:0];
      cmd_o.data           = s_axil_w_i.data[axil_packer_pkg::PAYLOAD_DATA_WIDTH-1:0];
    end
  end

  // Every response is OKAY
  assign s_axil_b_o.resp = axil_packer_pkg::e_axi_resp_okay;
  assign s_axil_r_o.data = resp_i;
  assign s_axil_r_o.resp = axil_packer_pkg::e_axi_resp_okay;

  assign s_axil_bvalid_o = (state_r == e_write_resp);
  assign s_axil_rvalid_o = (state_r == e_read_resp) & resp_v_i;
  assign resp_ready_o    = (state_r == e_read_resp) & s_axil_rready_i;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
        if (accept)
          state_n = pick_read ? e_read_resp : e_write_resp;
      e_write_resp:
        if (s_axil_bready_i)
          state_n = e_idle;
      e_read_resp:
        if (s_axil_rvalid_o & s_axil_rready_i)
          state_n = e_idle;
      default:
        state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_idle;
    else
      state_r <= state_n;
  end

  // An offered command is not withdrawn, and a read command does not change
  a_cmd_held: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_o && !cmd_ready_i |=>
      cmd_v_o && ($past(cmd_o.write_not_read) || $stable(cmd_o)));

  // A stalled read response keeps its data until rready
  a_r_held: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_r_o));

endmodule

`default_nettype wire

//--- rtl/axil_packer_top.sv
/*
 * AXI4-Lite byte peripheral top
 * Packer, command FIFO, byte memory target and response FIFO
 */
`default_nettype none

module axil_packer_top (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,

  input  wire axil_packer_pkg::axil_aw_s  s_axil_aw_i,
  input  wire logic                       s_axil_awvalid_i,
  output logic                            s_axil_awready_o,

  input  wire axil_packer_pkg::axil_w_s   s_axil_w_i,
  input  wire logic                       s_axil_wvalid_i,
  output logic                            s_axil_wready_o,

  output axil_packer_pkg::axil_b_s        s_axil_b_o,
  output logic                            s_axil_bvalid_o,
  input  wire logic                       s_axil_bready_i,

  input  wire axil_packer_pkg::axil_ar_s  s_axil_ar_i,
  input  wire logic                       s_axil_arvalid_i,
  output logic                            s_axil_arready_o,

  output axil_packer_pkg::axil_r_s        s_axil_r_o,
  output logic                            s_axil_rvalid_o,
  input  wire logic                       s_axil_rready_i
);

  // Packer side and target side of the command FIFO
  axil_packer_pkg::packed_cmd_s pk_cmd;
  logic                         pk_cmd_v;
  logic                         pk_cmd_ready;
  axil_packer_pkg::packed_cmd_s tg_cmd;
  logic                         tg_cmd_v;
  logic                         tg_cmd_ready;

  // Target side and packer side of the response FIFO
  axil_packer_pkg::mem_resp_t   tg_resp;
  logic                         tg_resp_v;
  logic                         tg_resp_ready;
  axil_packer_pkg::mem_resp_t   pk_resp;
  logic                         pk_resp_v;
  logic                         pk_resp_ready;

  axil_store_packer u_packer (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_aw_i      (s_axil_aw_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_w_i       (s_axil_w_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_b_o       (s_axil_b_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_ar_i      (s_axil_ar_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_r_o       (s_axil_r_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .cmd_o            (pk_cmd),
    .cmd_v_o          (pk_cmd_v),
    .cmd_ready_i      (pk_cmd_ready),
    .resp_i           (pk_resp),
    .resp_v_i         (pk_resp_v),
    .resp_ready_o     (pk_resp_ready)
  );

  cmd_fifo #(
    .WIDTH (axil_packer_pkg::AXIL_DATA_WIDTH)
  ) u_cmd_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (pk_cmd),
    .v_i     (pk_cmd_v),
    .ready_o (pk_cmd_ready),
    .data_o  (tg_cmd),
    .v_o     (tg_cmd_v),
    .ready_i (tg_cmd_ready)
  );

  byte_mem_target u_target (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_i        (tg_cmd),
    .cmd_v_i      (tg_cmd_v),
    .cmd_ready_o  (tg_cmd_ready),
    .resp_o       (tg_resp),
    .resp_v_o     (tg_resp_v),
    .resp_ready_i (tg_resp_ready)
  );

  cmd_fifo #(
    .WIDTH (axil_packer_pkg::AXIL_DATA_WIDTH)
  ) u_resp_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (tg_resp),
    .v_i     (tg_resp_v),
    .ready_o (tg_resp_ready),
    .data_o  (pk_resp),
    .v_o     (pk_resp_v),
    .ready_i (pk_resp_ready)
  );

endmodule

`default_nettype wire

//--- test/axil_packer_tb.sv
/*
 * AXI4-Lite byte peripheral testbench
 * Drives writes and reads through the AXI4-Lite port and checks read data
 * and response handshakes against a byte-array reference model
 */
`default_nettype none

module axil_packer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 2000;

  logic clk_i;
  logic reset_i;

  axil_packer_pkg::axil_aw_s aw;
  logic                      awvalid;
  logic                      awready;
  axil_packer_pkg::axil_w_s  w;
  logic                      wvalid;
  logic                      wready;
  axil_packer_pkg::axil_b_s  b;
  logic                      bvalid;
  logic                      bready = 1'b1;
  axil_packer_pkg::axil_ar_s ar;
  logic                      arvalid;
  logic                      arready;
  axil_packer_pkg::axil_r_s  r;
  logic                      rvalid;
  logic                      rready = 1'b1;

  // Reference model with one byte per decoded address
  logic [7:0]  ref_mem [2**axil_packer_pkg::MEM_ADDR_WIDTH];
  logic        ref_written [2**axil_packer_pkg::MEM_ADDR_WIDTH];
  int          written_q [$];
  logic [31:0] exp_q [$];

  int          requests = 0;
  int          writes_issued = 0;
  int          reads_issued = 0;
  int          b_seen = 0;
  int          r_seen = 0;
  string       test_name = "reset_idle";
  logic        stall_en = 1'b0;
  logic [31:0] stim_state = 32'd60;
  logic [31:0] stall_state = 32'd60;

  axil_packer_top u_axil_packer_top (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_aw_i      (aw),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_w_i       (w),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_b_o       (b),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_ar_i      (ar),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_r_o       (r),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Address modulo 1024 picks the byte
  function automatic logic [31:0] expected_rdata(input logic [31:0] addr);
    return {24'h0, ref_mem[addr[9:0]]};
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic value_mismatch(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
    abort_run($sformatf("error %s %s expected %08h actual %08h",
                        test_name, what, expected, actual));
  endtask

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
    int idx;
    idx = int'(addr[9:0]);
    if (!ref_written[idx])
      written_q.push_back(idx);
    ref_written[idx] = 1'b1;
    ref_mem[idx]     = data[7:0];
  endtask

  // Blocks until every issued request has its response
  task automatic wait_responses();
    int waited;
    waited = 0;
    while (b_seen != writes_issued || r_seen != reads_issued)
    begin
      @(posedge clk_i);
      waited++;
      assert (waited < TIMEOUT_CYCLES)
      else abort_run($sformatf("%s: timeout waiting for a response", test_name));
    end
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    int waited;
    @(posedge clk_i);
    aw      <= '{addr: addr, prot: axil_packer_pkg::e_axi_prot_default};
    w       <= '{data: data, strb: 4'hf};
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    requests++;
    writes_issued++;
    model_write(addr, data);
    waited = 0;
    do
    begin
      @(negedge clk_i);
      waited++;
      assert (waited < TIMEOUT_CYCLES)
      else abort_run($sformatf("%s: timeout waiting for awready and wready", test_name));
    end while (!(awready && wready));
    @(posedge clk_i);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    wait_responses();
  endtask

  task automatic axil_read(input logic [31:0] addr);
    int waited;
    @(posedge clk_i);
    ar      <= '{addr: addr, prot: axil_packer_pkg::e_axi_prot_default};
    arvalid <= 1'b1;
    requests++;
    reads_issued++;
    exp_q.push_back(expected_rdata(addr));
    waited = 0;
    do
    begin
      @(negedge clk_i);
      waited++;
      assert (waited < TIMEOUT_CYCLES)
      else abort_run($sformatf("%s: timeout waiting for arready", test_name));
    end while (!arready);
    @(posedge clk_i);
    arvalid <= 1'b0;
    wait_responses();
  endtask

  // Write and read offered in the same cycle
  task automatic axil_write_read_together(input logic [31:0] addr,
                                          input logic [31:0] data);
    int waited;
    @(posedge clk_i);
    ar      <= '{addr: addr, prot: axil_packer_pkg::e_axi_prot_default};
    aw      <= '{addr: addr, prot: axil_packer_pkg::e_axi_prot_default};
    w       <= '{data: data, strb: 4'hf};
    arvalid <= 1'b1;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    requests++;
    reads_issued++;
    writes_issued++;
    // Read goes first and sees the old byte
    exp_q.push_back(expected_rdata(addr));
    model_write(addr, data);
    waited = 0;
    do
    begin
      @(negedge clk_i);
      waited++;
      assert (waited < TIMEOUT_CYCLES)
      else abort_run($sformatf("%s: timeout waiting for arready", test_name));
      assert (!awready && !wready)
      else abort_run($sformatf("%s: write accepted ahead of the read", test_name));
    end while (!arready);
    @(posedge clk_i);
    arvalid <= 1'b0;
    waited = 0;
    do
    begin
      @(negedge clk_i);
      waited++;
      assert (waited < TIMEOUT_CYCLES)
      else abort_run($sformatf("%s: timeout waiting for awready and wready", test_name));
    end while (!(awready && wready));
    @(posedge clk_i);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    wait_responses();
  endtask

  // Reads only go to bytes that were written before
  task automatic run_random(input int count);
    logic [31:0] addr;
    logic [31:0] data;
    int          pick;
    int          idx;
    for (int i = 0; i < count; i++)
    begin
      stim_state = lcg_next(stim_state);
      addr       = stim_state;
      stim_state = lcg_next(stim_state);
      data       = stim_state;
      stim_state = lcg_next(stim_state);
      if (written_q.size() == 0 || stim_state[31])
        axil_write(addr, data);
      else
      begin
        pick       = int'(stim_state[30:16]) % written_q.size();
        idx        = written_q[pick];
        addr[9:0]  = idx[9:0];
        axil_read(addr);
      end
    end
  endtask

  // Ready stalls of random length when enabled
  always @(posedge clk_i)
  begin
    stall_state = lcg_next(stall_state);
    if (stall_en)
    begin
      bready <= (stall_state[31:30] == 2'b00);
      rready <= (stall_state[29:28] == 2'b00);
    end
    else
    begin
      bready <= 1'b1;
      rready <= 1'b1;
    end
  end

  // Compare process sampling at the falling edge where everything is settled
  initial
  begin : compare_responses
    logic        b_hold;
    logic        r_hold;
    logic [31:0] r_prev;
    logic [31:0] expected;
    b_hold = 1'b0;
    r_hold = 1'b0;
    r_prev = '0;
    forever
    begin
      @(negedge clk_i);
      if (requests == 0)
        assert (!bvalid && !rvalid)
        else abort_run($sformatf("%s: response valid before any request", test_name));
      if (b_hold)
        assert (bvalid)
        else abort_run($sformatf("%s: bvalid dropped before bready", test_name));
      if (r_hold)
      begin
        assert (rvalid)
        else abort_run($sformatf("%s: rvalid dropped before rready", test_name));
        assert (r.data == r_prev)
        else value_mismatch("stalled rdata", r_prev, r.data);
      end
      if (bvalid && bready)
      begin
        assert (b_seen < writes_issued)
        else abort_run($sformatf("%s: write response with no write outstanding", test_name));
        assert (b.resp == axil_packer_pkg::e_axi_resp_okay)
        else value_mismatch("bresp", 32'(axil_packer_pkg::e_axi_resp_okay), 32'(b.resp));
        b_seen++;
      end
      if (rvalid && rready)
      begin
        assert (exp_q.size() > 0)
        else abort_run($sformatf("%s: read response with no read outstanding", test_name));
        expected = exp_q.pop_front();
        assert (r.data == expected)
        else value_mismatch("rdata", expected, r.data);
        assert (r.resp == axil_packer_pkg::e_axi_resp_okay)
        else value_mismatch("rresp", 32'(axil_packer_pkg::e_axi_resp_okay), 32'(r.resp));
        r_seen++;
      end
      b_hold = bvalid && !bready;
      r_hold = rvalid && !rready;
      r_prev = r.data;
    end
  end

  initial
  begin
    reset_i <= 1'b1;
    aw      <= '0;
    awvalid <= 1'b0;
    w       <= '0;
    wvalid  <= 1'b0;
    ar      <= '0;
    arvalid <= 1'b0;
    foreach (ref_written[i])
      ref_written[i] = 1'b0;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    // No response may appear while idle after reset
    repeat (8) @(posedge clk_i);

    test_name = "single_write_read";
    axil_write(32'h0000_0123, 32'ha5c3_e17b);
    axil_read(32'h0000_0123);

    test_name = "aliasing";
    axil_write(32'h0000_0040, 32'h1234_565a);
    axil_read(32'h0000_0440);

    test_name = "read_priority";
    axil_write(32'h0000_0200, 32'h0000_0011);
    axil_write_read_together(32'h0000_0200, 32'h0000_0022);
    axil_read(32'h0000_0200);

    test_name = "random_mix";
    run_random(200);

    test_name = "backpressure";
    stall_en <= 1'b1;
    run_random(100);
    stall_en <= 1'b0;

    // Quiet cycles so a late or repeated response is still seen
    repeat (16) @(posedge clk_i);

    if (b_seen == writes_issued && r_seen == reads_issued && exp_q.size() == 0)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
      abort_run("response count does not match request count");
  end

endmodule

`default_nettype wire

//--- axil_packer.f
rtl/axil_packer_pkg.sv
rtl/cmd_fifo.sv
rtl/byte_mem_target.sv
rtl/axil_store_packer.sv
rtl/axil_packer_top.sv
test/axil_packer_tb.sv

//--- Makefile
# Verilator flow for the AXI4-Lite byte peripheral
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= axil_packer_tb
FILELIST  ?= axil_packer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** TEST PASSED ***
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF -- '$(PASS_MSG)' $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
